/* list.f */
+incdir+tests
hw/gpio_pkg.sv
hw/axi4l_slave_port.sv
hw/gpio_regfile.sv
hw/gpio_pad_bank.sv
hw/axi4l_gpio.sv
tests/gpio_tb.sv

/* Makefile */
# Verilator flow for the AXI4-Lite GPIO peripheral

TOOL       = verilator
TOP        = gpio_tb
FILELIST   = list.f
LINT_FLAGS = --lint-only --timing --top-module $(TOP)
SIM_FLAGS  = --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

# The log decides the result, not the simulator's exit status
sim:
	$(TOOL) $(SIM_FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/gpio_tb_tasks.svh */
// GPIO testbench bus tasks
`ifndef GPIO_TB_TASKS_SVH
`define GPIO_TB_TASKS_SVH

int checks = 0;
int errors = 0;
int err_mark = 0;        // Errors before the running test
int wait_limit = 50;     // Cycles allowed for any single wait

////////////////////////////////////////////////////////////////////////
// Checks and counters
////////////////////////////////////////////////////////////////////////

task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
  checks++;
  assert (got === exp) else begin
    errors++;
    $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  check_val(name, 64'(got), 64'(exp));
endtask

task automatic report_timeout(input string what);
  errors++;
  $display("ERROR at %0t ns: gave up waiting for %s", $time, what);
endtask

task automatic end_test(input int num, input string name);
  $display("Test %0d %s done with %0d errors", num, name, errors - err_mark);
  err_mark = errors;
endtask

////////////////////////////////////////////////////////////////////////
// Bus channels driven from falling edges
////////////////////////////////////////////////////////////////////////

task automatic drive_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [2:0] prot);
  req.aw_addr  = addr;
  req.aw_prot  = prot;
  req.w_data   = data;
  req.w_strb   = strb;
  req.aw_valid = 1'b1;
  req.w_valid  = 1'b1;
endtask

task automatic drive_read(input logic [7:0] addr, input logic [2:0] prot);
  req.ar_addr  = addr;
  req.ar_prot  = prot;
  req.ar_valid = 1'b1;
endtask

// Drop each valid once its ready was seen across a rising edge
task automatic finish_handshakes();
  int n;
  logic aw_go, w_go, ar_go;
  n = 0;
  while ((req.aw_valid || req.w_valid || req.ar_valid) && n < wait_limit) begin
    aw_go = req.aw_valid && resp.aw_ready;
    w_go  = req.w_valid && resp.w_ready;
    ar_go = req.ar_valid && resp.ar_ready;
    @(negedge clk);
    if (aw_go) req.aw_valid = 1'b0;
    if (w_go) req.w_valid = 1'b0;
    if (ar_go) req.ar_valid = 1'b0;
    n++;
  end
  if (req.aw_valid || req.w_valid || req.ar_valid) begin
    report_timeout("an address or write data handshake");
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    req.ar_valid = 1'b0;
  end
endtask

task automatic wait_b(output logic [1:0] br);
  int n;
  n = 0;
  while (!resp.b_valid && n < wait_limit) begin
    @(negedge clk);
    n++;
  end
  if (!resp.b_valid) report_timeout("the write response");
  br = resp.b_resp;
endtask

task automatic wait_r(output logic [31:0] data, output logic [1:0] rr);
  int n;
  n = 0;
  while (!resp.r_valid && n < wait_limit) begin
    @(negedge clk);
    n++;
  end
  if (!resp.r_valid) report_timeout("the read response");
  data = resp.r_data;
  rr   = resp.r_resp;
endtask

task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input logic [2:0] prot,
                         output logic [1:0] br);
  @(negedge clk);
  drive_write(addr, data, strb, prot);
  finish_handshakes();
  wait_b(br);
  @(negedge clk);  // B taken on the edge in between
endtask

task automatic bus_read(input logic [7:0] addr, input logic [2:0] prot,
                        output logic [31:0] data, output logic [1:0] rr);
  @(negedge clk);
  drive_read(addr, prot);
  finish_handshakes();
  wait_r(data, rr);
  @(negedge clk);
endtask

`endif

/* tests/gpio_tb.sv */
// GPIO peripheral testbench
`timescale 1ns/1ns
`default_nettype none

module gpio_tb;

  logic clk = 1'b0;
  logic reset;
  gpio_pkg::axi4l_req_t  req;
  gpio_pkg::axi4l_resp_t resp;

  logic [63:0] pin_level, pin_out, pin_oe, pull_up, pull_down;
  logic [63:0] ext_en, ext_val;     // Outside source on the pins
  logic [63:0] wdata_m, wen_m, pull_m;  // Shadow registers
  integer seed = 32'h69d8;

  always #5 clk = ~clk;

  axi4l_gpio uut (
    .clk_i       (clk),
    .reset_i     (reset),
    .req_i       (req),
    .resp_o      (resp),
    .pin_i       (pin_level),
    .pin_o       (pin_out),
    .pin_oe_o    (pin_oe),
    .pull_up_o   (pull_up),
    .pull_down_o (pull_down)
  );

  // Pin level from strong drive, then outside source, then pull, else low
  assign pin_level = (pin_oe & pin_out) | (~pin_oe & ext_en & ext_val) |
                     (~pin_oe & ~ext_en & pull_up);

  `include "gpio_tb_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // Shadow model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [63:0] expected_level();
    return (wen_m & wdata_m) | (~wen_m & ext_en & ext_val) |
           (~wen_m & ~ext_en & pull_m & wdata_m);
  endfunction

  function automatic logic [31:0] model_word(input logic [7:0] addr);
    logic [63:0] blk;
    case (addr[4:3])
      2'd0: blk = expected_level();  // rdata
      2'd1: blk = wdata_m;
      2'd2: blk = wen_m;
      default: blk = pull_m;
    endcase
    return addr[2] ? blk[63:32] : blk[31:0];
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [2:0] prot,
                             output logic [1:0] exp_resp);
    int lo;
    lo = addr[2] ? 32 : 0;
    exp_resp = 2'b00;
    if (prot[1] || addr >= 8'h20 || addr < 8'h08) begin
      exp_resp = 2'b10;  // Privileged, rdata or past the map
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          case (addr[4:3])
            2'd1: wdata_m[lo + 8*b +: 8] = data[8*b +: 8];
            2'd2: wen_m[lo + 8*b +: 8] = data[8*b +: 8];
            default: pull_m[lo + 8*b +: 8] = data[8*b +: 8];
          endcase
        end
      end
    end
  endtask

  task automatic write_check(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [2:0] prot);
    logic [1:0] exp_b, got_b;
    model_write(addr, data, strb, prot, exp_b);
    bus_write(addr, data, strb, prot, got_b);
    check_val($sformatf("b_resp[%02h]", addr), 64'(got_b), 64'(exp_b));
    check_val("pin_o", pin_out, wdata_m);
    check_val("pin_oe_o", pin_oe, wen_m);
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [2:0] prot);
    logic [31:0] data;
    logic [1:0]  rr;
    logic        bad;
    bad = prot[1] || addr >= 8'h20;
    bus_read(addr, prot, data, rr);
    check_val($sformatf("r_data[%02h]", addr), 64'(data), bad ? 64'd0 : 64'(model_word(addr)));
    check_val($sformatf("r_resp[%02h]", addr), 64'(rr), bad ? 64'd2 : 64'd0);
  endtask

  task automatic check_all_words();
    for (int k = 0; k < 6; k++) read_check(8'h08 + 8'(4 * k), 3'b000);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [1:0]  br;
    logic [1:0]  exp_b;
    logic [1:0]  rr;
    logic [31:0] d;
    int          idx;
    req = '0;
    req.b_ready = 1'b1;
    req.r_ready = 1'b1;
    reset = 1'b1;
    {ext_en, ext_val} = '0;
    {wdata_m, wen_m, pull_m} = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Test 1 with everything idle and cleared
    check_flag("aw_ready", resp.aw_ready, 1'b0);
    check_flag("w_ready", resp.w_ready, 1'b0);
    check_flag("b_valid", resp.b_valid, 1'b0);
    check_flag("ar_ready", resp.ar_ready, 1'b0);
    check_flag("r_valid", resp.r_valid, 1'b0);
    check_val("pin_oe_o", pin_oe, '0);
    check_val("pull_up_o", pull_up, '0);
    check_val("pull_down_o", pull_down, '0);
    check_all_words();
    end_test(1, "reset state");

    // Test 2 writes random words through random byte lanes
    repeat (24) begin
      idx = $unsigned($random(seed)) % 6;
      write_check(8'h08 + 8'(4 * idx), $random(seed), 4'($random(seed)), 3'b000);
      read_check(8'h08 + 8'(4 * idx), 3'b000);
    end
    check_all_words();
    end_test(2, "byte-strobed writes");

    // Test 3 checks that every error leaves the registers alone
    write_check(8'h00, $random(seed), 4'hF, 3'b000);
    write_check(8'h04, $random(seed), 4'hF, 3'b000);
    write_check(8'h0C, $random(seed), 4'hF, 3'b010);
    write_check(8'h20, $random(seed), 4'hF, 3'b000);
    write_check(8'hF8, $random(seed), 4'hF, 3'b000);
    check_all_words();
    read_check(8'h20, 3'b000);
    read_check(8'hFC, 3'b000);
    read_check(8'h10, 3'b010);
    read_check(8'h08, 3'b011);
    end_test(3, "errors");

    // Test 4 has pulls only where not driven
    repeat (3) begin
      for (int k = 0; k < 6; k++) write_check(8'h08 + 8'(4 * k), $random(seed), 4'hF, 3'b000);
      check_val("pull_up_o", pull_up, pull_m & ~wen_m & wdata_m);
      check_val("pull_down_o", pull_down, pull_m & ~wen_m & ~wdata_m);
      repeat (3) @(posedge clk);  // Synchronizer settles
      read_check(8'h00, 3'b000);
      read_check(8'h04, 3'b000);
    end
    end_test(4, "pull and drive");

    // Test 5 puts an outside source on every undriven pin
    repeat (4) begin
      @(negedge clk);
      ext_en  = ~wen_m;
      ext_val = {$random(seed), $random(seed)};
      repeat (3) @(posedge clk);
      read_check(8'h00, 3'b000);
      read_check(8'h04, 3'b000);
    end
    end_test(5, "external input");

    // Test 6 holds both responses and blocks a second write meanwhile
    @(negedge clk);
    req.b_ready = 1'b0;
    req.r_ready = 1'b0;
    d = $random(seed);
    model_write(8'h08, d, 4'hF, 3'b000, exp_b);
    drive_write(8'h08, d, 4'hF, 3'b000);
    drive_read(8'h14, 3'b000);
    finish_handshakes();
    wait_b(br);
    check_val("b_resp", 64'(br), 64'(exp_b));
    wait_r(d, rr);
    check_val("r_data", 64'(d), 64'(model_word(8'h14)));
    check_val("r_resp", 64'(rr), 64'd0);
    d = $random(seed);
    drive_write(8'h0C, d, 4'hF, 3'b000);
    repeat (4) begin
      @(negedge clk);
      check_flag("b_valid", resp.b_valid, 1'b1);
      check_flag("r_valid", resp.r_valid, 1'b1);
      check_flag("aw_ready", resp.aw_ready, 1'b0);
      check_flag("w_ready", resp.w_ready, 1'b0);
    end
    check_val("b_resp", 64'(resp.b_resp), 64'(exp_b));
    check_val("r_data", 64'(resp.r_data), 64'(model_word(8'h14)));
    check_val("r_resp", 64'(resp.r_resp), 64'd0);
    req.b_ready = 1'b1;
    req.r_ready = 1'b1;
    model_write(8'h0C, d, 4'hF, 3'b000, exp_b);
    finish_handshakes();
    wait_b(br);
    check_val("b_resp", 64'(br), 64'(exp_b));
    @(negedge clk);
    check_val("pin_o", pin_out, wdata_m);
    check_all_words();
    end_test(6, "back-pressure");

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/axi4l_gpio.sv */
// AXI4-Lite GPIO top level
`timescale 1ns/1ns
`default_nettype none

module axi4l_gpio (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  gpio_pkg::axi4l_req_t            req_i,
  output gpio_pkg::axi4l_resp_t           resp_o,
  input  logic [gpio_pkg::PIN_COUNT-1:0]  pin_i,        // Resolved pin level
  output logic [gpio_pkg::PIN_COUNT-1:0]  pin_o,        // Drive value
  output logic [gpio_pkg::PIN_COUNT-1:0]  pin_oe_o,     // Strong drive enable
  output logic [gpio_pkg::PIN_COUNT-1:0]  pull_up_o,
  output logic [gpio_pkg::PIN_COUNT-1:0]  pull_down_o
);

  //////////////////////////////////////////////////////////////////////
  // Internal connections
  //////////////////////////////////////////////////////////////////////

  gpio_pkg::reg_cmd_t             cmd;       // Port to regfile strobes
  gpio_pkg::reg_rsp_t             rsp;       // Regfile answers
  gpio_pkg::gpio_ctrl_t           ctrl;      // Register contents to pads
  logic [gpio_pkg::PIN_COUNT-1:0] pin_sync;  // rdata block

  // Bus channels into strobes
  axi4l_slave_port u_port (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req_i),
    .resp_o  (resp_o),
    .cmd_o   (cmd),
    .rsp_i   (rsp)
  );

  // Decode, error rule and storage
  gpio_regfile u_regfile (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cmd_i      (cmd),
    .rsp_o      (rsp),
    .ctrl_o     (ctrl),
    .pin_sync_i (pin_sync)
  );

  gpio_pad_bank u_pads (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ctrl_i      (ctrl),
    .pin_i       (pin_i),
    .pin_o       (pin_o),
    .pin_oe_o    (pin_oe_o),
    .pull_up_o   (pull_up_o),
    .pull_down_o (pull_down_o),
    .pin_sync_o  (pin_sync)
  );

endmodule

`default_nettype wire

/* hw/gpio_pad_bank.sv */
// GPIO pad bank
`timescale 1ns/1ns
`default_nettype none

module gpio_pad_bank (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  gpio_pkg::gpio_ctrl_t            ctrl_i,
  input  logic [gpio_pkg::PIN_COUNT-1:0]  pin_i,
  output logic [gpio_pkg::PIN_COUNT-1:0]  pin_o,
  output logic [gpio_pkg::PIN_COUNT-1:0]  pin_oe_o,
  output logic [gpio_pkg::PIN_COUNT-1:0]  pull_up_o,
  output logic [gpio_pkg::PIN_COUNT-1:0]  pull_down_o,
  output logic [gpio_pkg::PIN_COUNT-1:0]  pin_sync_o
);

  //////////////////////////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////////////////////////

  // Strong drive straight from the registers
  assign pin_o    = ctrl_i.wdata;
  assign pin_oe_o = ctrl_i.wen;

  // Weak drive only on pins not strongly driven
  logic [gpio_pkg::PIN_COUNT-1:0] pull_act;
  assign pull_act = ctrl_i.pull & ~ctrl_i.wen;

  assign pull_up_o   = pull_act & ctrl_i.wdata;   // Pull toward 1
  assign pull_down_o = pull_act & ~ctrl_i.wdata;  // Pull toward 0

  //////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////

  // Pin level is asynchronous to clk_i
  logic [gpio_pkg::PIN_COUNT-1:0] pin_meta_q;  // First stage that may go metastable
  logic [gpio_pkg::PIN_COUNT-1:0] pin_sync_q;  // Second stage is safe to use

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pin_meta_q <= '0;
      pin_sync_q <= '0;
    end else begin
      pin_meta_q <= pin_i;
      pin_sync_q <= pin_meta_q;
    end
  end

  // Two edges of latency into rdata
  assign pin_sync_o = pin_sync_q;

endmodule

`default_nettype wire

/* hw/gpio_regfile.sv */
// GPIO register file
`timescale 1ns/1ns
`default_nettype none

module gpio_regfile (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  gpio_pkg::reg_cmd_t                  cmd_i,
  output gpio_pkg::reg_rsp_t                  rsp_o,
  output gpio_pkg::gpio_ctrl_t                ctrl_o,
  input  logic [gpio_pkg::PIN_COUNT-1:0]      pin_sync_i
);

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  // Base of the block holding addr
  function automatic logic [gpio_pkg::ADDR_WIDTH-1:0] base_of(
    input logic [gpio_pkg::ADDR_WIDTH-1:0] addr
  );
    if (addr >= gpio_pkg::PULL_BASE) return gpio_pkg::PULL_BASE;  // Also past map end
    if (addr >= gpio_pkg::WEN_BASE) return gpio_pkg::WEN_BASE;
    if (addr >= gpio_pkg::WDATA_BASE) return gpio_pkg::WDATA_BASE;
    return gpio_pkg::RDATA_BASE;
  endfunction

  // Word within the block
  function automatic logic [gpio_pkg::ROW_BITS-1:0] row_of(
    input logic [gpio_pkg::ADDR_WIDTH-1:0] addr,
    input logic [gpio_pkg::ADDR_WIDTH-1:0] base
  );
    logic [gpio_pkg::ADDR_WIDTH-1:0] offset;
    offset = addr - base;
    return offset[gpio_pkg::BLOCK_LSB-1:gpio_pkg::WORD_LSB];  // Byte lanes dropped
  endfunction

  // Keep cur outside mask, take val inside
  function automatic logic [gpio_pkg::PIN_COUNT-1:0] merge(
    input logic [gpio_pkg::PIN_COUNT-1:0] cur,
    input logic [gpio_pkg::PIN_COUNT-1:0] val,
    input logic [gpio_pkg::PIN_COUNT-1:0] mask
  );
    return (cur & ~mask) | (val & mask);
  endfunction

  logic [gpio_pkg::ADDR_WIDTH-1:0] wr_base, rd_base;
  logic [gpio_pkg::ROW_BITS-1:0]   wr_row, rd_row;
  logic                            wr_err, rd_err;

  assign wr_base = base_of(cmd_i.wr_addr);
  assign wr_row  = row_of(cmd_i.wr_addr, wr_base);
  assign rd_base = base_of(cmd_i.rd_addr);
  assign rd_row  = row_of(cmd_i.rd_addr, rd_base);

  // Privileged prot, outside map or rdata written all give SLVERR
  assign wr_err = cmd_i.wr_prot[1] || (cmd_i.wr_addr >= gpio_pkg::MAP_END) ||
                  (wr_base == gpio_pkg::RDATA_BASE);
  assign rd_err = cmd_i.rd_prot[1] || (cmd_i.rd_addr >= gpio_pkg::MAP_END);

  assign rsp_o.wr_resp = wr_err ? gpio_pkg::SLVERR : gpio_pkg::OKAY;  // Port samples in pulse

  //////////////////////////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////////////////////////

  logic [gpio_pkg::PIN_COUNT-1:0] wr_mask;  // Strobed bytes of the addressed word
  logic [gpio_pkg::PIN_COUNT-1:0] wr_val;   // Bus word placed at its row

  always_comb begin
    wr_mask = '0;
    wr_val  = '0;
    for (int b = 0; b < gpio_pkg::STRB_WIDTH; b++) begin
      wr_mask[wr_row*gpio_pkg::DATA_WIDTH + b*8 +: 8] = {8{cmd_i.wr_strb[b]}};
    end
    wr_val[wr_row*gpio_pkg::DATA_WIDTH +: gpio_pkg::DATA_WIDTH] = cmd_i.wr_data;
  end

  gpio_pkg::gpio_ctrl_t ctrl_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q <= '0;  // Pins released with no pulls
    end else if (cmd_i.wr_en && !wr_err) begin
      case (wr_base)
        gpio_pkg::WDATA_BASE: ctrl_q.wdata <= merge(ctrl_q.wdata, wr_val, wr_mask);
        gpio_pkg::WEN_BASE:   ctrl_q.wen   <= merge(ctrl_q.wen, wr_val, wr_mask);
        gpio_pkg::PULL_BASE:  ctrl_q.pull  <= merge(ctrl_q.pull, wr_val, wr_mask);
        default: ;  // rdata never reaches here
      endcase
    end
  end

  assign ctrl_o = ctrl_q;  // Seen by pads on the storing edge

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  logic [gpio_pkg::PIN_COUNT-1:0]  rd_block;
  logic [gpio_pkg::DATA_WIDTH-1:0] rd_word;

  always_comb begin
    case (rd_base)
      gpio_pkg::RDATA_BASE: rd_block = pin_sync_i;  // Synchronized pin level
      gpio_pkg::WDATA_BASE: rd_block = ctrl_q.wdata;
      gpio_pkg::WEN_BASE:   rd_block = ctrl_q.wen;
      default:              rd_block = ctrl_q.pull;
    endcase
    rd_word = rd_block[rd_row*gpio_pkg::DATA_WIDTH +: gpio_pkg::DATA_WIDTH];
  end

  logic [gpio_pkg::DATA_WIDTH-1:0] rd_data_q;
  gpio_pkg::axi_resp_e             rd_resp_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) rd_resp_q <= gpio_pkg::OKAY;
    else if (cmd_i.rd_en) rd_resp_q <= rd_err ? gpio_pkg::SLVERR : gpio_pkg::OKAY;
  end

  always_ff @(posedge clk_i) begin
    if (cmd_i.rd_en) rd_data_q <= rd_err ? '0 : rd_word;  // Zero on error
  end

  assign rsp_o.rd_data = rd_data_q;
  assign rsp_o.rd_resp = rd_resp_q;

endmodule

`default_nettype wire

/* hw/axi4l_slave_port.sv */
// AXI4-Lite slave port
`timescale 1ns/1ns
`default_nettype none

module axi4l_slave_port (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  gpio_pkg::axi4l_req_t   req_i,
  output gpio_pkg::axi4l_resp_t  resp_o,
  output gpio_pkg::reg_cmd_t     cmd_o,
  input  gpio_pkg::reg_rsp_t     rsp_i
);

  //////////////////////////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////////////////////////

  gpio_pkg::port_state_e state_q;

  logic aw_full_q, w_full_q;    // Slot occupancy
  logic aw_ready_q, w_ready_q;  // One cycle ready pulses
  logic b_valid_q;
  gpio_pkg::axi_resp_e b_resp_q;

  // Slot payloads
  logic [gpio_pkg::ADDR_WIDTH-1:0] aw_addr_q;
  logic [2:0]                      aw_prot_q;
  logic [gpio_pkg::DATA_WIDTH-1:0] w_data_q;
  logic [gpio_pkg::STRB_WIDTH-1:0] w_strb_q;

  logic aw_hs, w_hs;
  assign aw_hs = req_i.aw_valid && aw_ready_q;
  assign w_hs  = req_i.w_valid && w_ready_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= gpio_pkg::WR_COLLECT;
      aw_full_q  <= 1'b0;
      w_full_q   <= 1'b0;
      aw_ready_q <= 1'b0;
      w_ready_q  <= 1'b0;
      b_valid_q  <= 1'b0;
    end else begin
      aw_ready_q <= 1'b0;  // Ready only ever lasts one cycle
      w_ready_q  <= 1'b0;
      case (state_q)
        gpio_pkg::WR_COLLECT: begin
          if (aw_hs) aw_full_q <= 1'b1;
          else if (!aw_full_q && req_i.aw_valid && !aw_ready_q) aw_ready_q <= 1'b1;
          if (w_hs) w_full_q <= 1'b1;
          else if (!w_full_q && req_i.w_valid && !w_ready_q) w_ready_q <= 1'b1;
          // Both slots loaded on an earlier edge
          if (aw_full_q && w_full_q) state_q <= gpio_pkg::WR_ISSUE;
        end
        gpio_pkg::WR_ISSUE: begin  // wr_en high this cycle
          state_q   <= gpio_pkg::WR_RESPOND;
          b_valid_q <= 1'b1;
          aw_full_q <= 1'b0;
          w_full_q  <= 1'b0;
        end
        gpio_pkg::WR_RESPOND: begin
          if (req_i.b_ready) begin  // B accepted
            b_valid_q <= 1'b0;
            state_q   <= gpio_pkg::WR_COLLECT;
          end
        end
        default: state_q <= gpio_pkg::WR_COLLECT;
      endcase
    end
  end

  // Slot payloads and B response
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_addr_q <= req_i.aw_addr;
      aw_prot_q <= req_i.aw_prot;
    end
    if (w_hs) begin
      w_data_q <= req_i.w_data;
      w_strb_q <= req_i.w_strb;
    end
    if (state_q == gpio_pkg::WR_ISSUE) b_resp_q <= rsp_i.wr_resp;  // Judged by regfile
  end

  //////////////////////////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////////////////////////

  logic ar_ready_q;
  logic rd_issue_q;  // rd_en cycle
  logic rd_wait_q;   // Regfile output settling
  logic r_valid_q;
  logic [gpio_pkg::ADDR_WIDTH-1:0] ar_addr_q;
  logic [2:0]                      ar_prot_q;
  logic [gpio_pkg::DATA_WIDTH-1:0] r_data_q;
  gpio_pkg::axi_resp_e             r_resp_q;

  logic ar_hs, rd_busy;
  assign ar_hs   = req_i.ar_valid && ar_ready_q;
  assign rd_busy = rd_issue_q || rd_wait_q || r_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ar_ready_q <= 1'b0;
      rd_issue_q <= 1'b0;
      rd_wait_q  <= 1'b0;
      r_valid_q  <= 1'b0;
    end else begin
      ar_ready_q <= req_i.ar_valid && !ar_ready_q && !rd_busy;
      rd_issue_q <= ar_hs;
      rd_wait_q  <= rd_issue_q;
      if (rd_wait_q) r_valid_q <= 1'b1;
      else if (req_i.r_ready) r_valid_q <= 1'b0;  // Held until taken
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      ar_addr_q <= req_i.ar_addr;
      ar_prot_q <= req_i.ar_prot;
    end
    if (rd_wait_q) begin  // Registered read data now stable
      r_data_q <= rsp_i.rd_data;
      r_resp_q <= rsp_i.rd_resp;
    end
  end

  // Command strobes
  assign cmd_o.wr_en   = (state_q == gpio_pkg::WR_ISSUE);
  assign cmd_o.wr_addr = aw_addr_q;
  assign cmd_o.wr_data = w_data_q;
  assign cmd_o.wr_strb = w_strb_q;
  assign cmd_o.wr_prot = aw_prot_q;
  assign cmd_o.rd_en   = rd_issue_q;
  assign cmd_o.rd_addr = ar_addr_q;
  assign cmd_o.rd_prot = ar_prot_q;

  // Bus outputs
  assign resp_o.aw_ready = aw_ready_q;
  assign resp_o.w_ready  = w_ready_q;
  assign resp_o.b_valid  = b_valid_q;
  assign resp_o.b_resp   = b_resp_q;
  assign resp_o.ar_ready = ar_ready_q;
  assign resp_o.r_valid  = r_valid_q;
  assign resp_o.r_data   = r_data_q;
  assign resp_o.r_resp   = r_resp_q;

endmodule

`default_nettype wire

/* hw/gpio_pkg.sv */
// GPIO peripheral shared definitions
`default_nettype none

package gpio_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int PORT_BYTES = 8;               // GPIO bytes
  localparam int PIN_COUNT  = PORT_BYTES * 8;  // One pin per bit
  localparam int DATA_WIDTH = 32;              // Bus word
  localparam int STRB_WIDTH = DATA_WIDTH / 8;  // One strobe per byte
  localparam int ADDR_WIDTH = 8;

  // Block spans the wider of port and bus word
  localparam int BLOCK_BYTES = (PORT_BYTES > STRB_WIDTH) ? PORT_BYTES : STRB_WIDTH;
  localparam int WORD_LSB    = $clog2(STRB_WIDTH);   // Byte offset bits
  localparam int BLOCK_LSB   = $clog2(BLOCK_BYTES);
  localparam int ROW_BITS    = BLOCK_LSB - WORD_LSB; // Word index within a block

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  localparam logic [ADDR_WIDTH-1:0] RDATA_BASE = ADDR_WIDTH'(BLOCK_BYTES * 0);  // Read only
  localparam logic [ADDR_WIDTH-1:0] WDATA_BASE = ADDR_WIDTH'(BLOCK_BYTES * 1);
  localparam logic [ADDR_WIDTH-1:0] WEN_BASE   = ADDR_WIDTH'(BLOCK_BYTES * 2);
  localparam logic [ADDR_WIDTH-1:0] PULL_BASE  = ADDR_WIDTH'(BLOCK_BYTES * 3);
  localparam logic [ADDR_WIDTH-1:0] MAP_END    = ADDR_WIDTH'(BLOCK_BYTES * 4);

  // Bus response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // Write slot sequencing in the slave port
  typedef enum logic [1:0] {
    WR_COLLECT,  // Gathering AW and W
    WR_ISSUE,    // Strobe into register file
    WR_RESPOND   // B held until accepted
  } port_state_e;

  // Manager side of the bus
  typedef struct packed {
    logic                  aw_valid;
    logic [ADDR_WIDTH-1:0] aw_addr;
    logic [2:0]            aw_prot;
    logic                  w_valid;
    logic [DATA_WIDTH-1:0] w_data;
    logic [STRB_WIDTH-1:0] w_strb;
    logic                  b_ready;
    logic                  ar_valid;
    logic [ADDR_WIDTH-1:0] ar_addr;
    logic [2:0]            ar_prot;
    logic                  r_ready;
  } axi4l_req_t;

  // Slave side of the bus
  typedef struct packed {
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;
    axi_resp_e             b_resp;
    logic                  ar_ready;
    logic                  r_valid;
    logic [DATA_WIDTH-1:0] r_data;
    axi_resp_e             r_resp;
  } axi4l_resp_t;

  // Single cycle strobes toward the register file
  typedef struct packed {
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] wr_data;
    logic [STRB_WIDTH-1:0] wr_strb;
    logic [2:0]            wr_prot;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [2:0]            rd_prot;
  } reg_cmd_t;

  typedef struct packed {
    axi_resp_e             wr_resp;  // Same cycle as wr_en
    logic [DATA_WIDTH-1:0] rd_data;  // One cycle after rd_en
    axi_resp_e             rd_resp;
  } reg_rsp_t;

  // Per-pin register contents
  typedef struct packed {
    logic [PIN_COUNT-1:0] wdata;
    logic [PIN_COUNT-1:0] wen;
    logic [PIN_COUNT-1:0] pull;
  } gpio_ctrl_t;

endpackage

`default_nettype wire
